// ==== bch_channel.f ====
verilog/channel_pkg.sv
verilog/bch_encoder.sv
verilog/error_injector.sv
verilog/channel_sequencer.sv
verilog/channel_top.sv
sim/tb_channel.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_channel \
    -f bch_channel.f -o tb_channel &&
./obj_dir/tb_channel 2>&1 | tee /dev/stderr | grep -q "All tests passed!" &&
echo "PASS" ||
{ echo "FAIL"; exit 1; }

// ==== sim/tb_channel.sv ====
`timescale 1ns/1ps

module tb_channel;

    localparam logic [31:0] seed        = 32'h1a1;
    localparam logic [10:0] gen_poly    = 11'b10100110111;
    localparam int          cycle_limit = 20000;    // about 40 frames of a few hundred cycles
    localparam int          frame_limit = 1000;

    logic        clk;
    logic        rst;
    logic        data_ready;
    logic [7:0]  data_in;
    logic        bch_enable;
    logic        inject_enable;
    logic [7:0]  error_count;
    logic [7:0]  data_out;
    logic [29:0] code_out;
    logic        output_ready;

    logic [31:0] lfsr_state;
    int          cycles;

    channel_top dut (
        .clk           (clk),
        .rst           (rst),
        .data_ready    (data_ready),
        .data_in       (data_in),
        .bch_enable    (bch_enable),
        .inject_enable (inject_enable),
        .error_count   (error_count),
        .data_out      (data_out),
        .code_out      (code_out),
        .output_ready  (output_ready)
    );

    always #4 clk = ~clk;

    task automatic abort_run();
        $display("Test failures found");
        $fatal(1);
    endtask

    // watchdog over the whole run
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("run stopped after reaching the limit of %0d cycles", cycle_limit);
            abort_run();
        end
    end

    // ------------------------------
    // stimulus and reference model
    // ------------------------------
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h80200003 : 32'h0);   // right shifting galois step
    endfunction

    task automatic random_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[30:0], lfsr_state[0]};   // one step per bit
        end
    endtask

    // remainder of nibble * x^10 by long division
    task automatic model_codeword(input logic [3:0] nibble, output logic [14:0] code);
        logic [14:0] r;
        r = {1'b0, nibble, 10'b0};
        for (int i = 14; i >= 10; i--) begin
            if (r[i])
                r = r ^ (15'(gen_poly) << (i - 10));
        end
        code = {1'b0, nibble, r[9:0]};
    endtask

    task automatic model_pair(input logic [7:0] word, output logic [29:0] pair);
        logic [14:0] hi;
        logic [14:0] lo;
        model_codeword(word[7:4], hi);
        model_codeword(word[3:0], lo);
        pair = {hi, lo};
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, expected);
            abort_run();
        end
    endtask

    // ------------------------------
    // request handling
    // ------------------------------
    task automatic send_request(input logic [7:0] word, input logic bch, input logic inj,
                                input logic [7:0] count);
        @(negedge clk);
        data_in       = word;
        bch_enable    = bch;
        inject_enable = inj;
        error_count   = count;
        data_ready    = 1'b1;
        @(negedge clk);
        data_ready = 1'b0;
        check_value("output_ready", 32'(output_ready), 32'h0);  // low right after accept
    endtask

    task automatic wait_output_ready();
        int waited;
        waited = 0;
        while (!output_ready) begin
            @(negedge clk);
            waited++;
            if (waited > frame_limit) begin
                $display("output_ready did not rise within %0d cycles", frame_limit);
                abort_run();
            end
        end
    endtask

    task automatic run_frame(input logic [7:0] word, input logic bch, input logic inj,
                             input logic [7:0] count);
        send_request(word, bch, inj, count);
        wait_output_ready();
    endtask

    // ------------------------------
    // directed tests
    // ------------------------------
    task automatic test_reset_state();
        check_value("output_ready", 32'(output_ready), 32'h0);
        check_value("data_out", 32'(data_out), 32'h0);
        check_value("code_out", 32'(code_out), 32'h0);
    endtask

    task automatic test_passthrough();
        logic [31:0] v;
        repeat (6) begin
            random_bits(8, v);
            run_frame(v[7:0], 1'b0, 1'b0, 8'd0);
            check_value("data_out", 32'(data_out), 32'(v[7:0]));
            check_value("code_out", 32'(code_out), 32'h0);
        end
    endtask

    task automatic test_encode_only();
        logic [31:0] v;
        logic [29:0] pair;
        repeat (6) begin
            random_bits(8, v);
            model_pair(v[7:0], pair);
            run_frame(v[7:0], 1'b1, 1'b0, 8'd0);
            check_value("code_out", 32'(code_out), 32'(pair));
            check_value("data_out", 32'(data_out), 32'h0);
        end
    endtask

    task automatic inject_raw_once(input logic [7:0] count);
        logic [31:0] v;
        int          flips;
        random_bits(8, v);
        run_frame(v[7:0], 1'b0, 1'b1, count);
        flips = (count > 8) ? 8 : int'(count);
        check_value("data_out flips", 32'($countones(data_out ^ v[7:0])), 32'(flips));
        check_value("code_out", 32'(code_out), 32'h0);
    endtask

    task automatic test_raw_inject();
        logic [31:0] c;
        inject_raw_once(8'd0);
        inject_raw_once(8'd3);
        inject_raw_once(8'd12);     // capped at the word width
        repeat (5) begin
            random_bits(4, c);
            inject_raw_once(c[7:0]);
        end
    endtask

    task automatic test_coded_inject();
        logic [31:0] v;
        logic [31:0] c;
        logic [29:0] pair;
        int          flips;
        repeat (8) begin
            random_bits(8, v);
            random_bits(6, c);
            model_pair(v[7:0], pair);
            run_frame(v[7:0], 1'b1, 1'b1, c[7:0]);
            flips = (c > 30) ? 30 : int'(c);
            check_value("code_out flips", 32'($countones(code_out ^ pair)), 32'(flips));
            check_value("data_out", 32'(data_out), 32'h0);
        end
    endtask

    task automatic test_ignored_edge();
        logic [29:0] first;
        logic [29:0] second;
        model_pair(8'h3c, first);
        model_pair(8'ha5, second);
        send_request(8'h3c, 1'b1, 1'b0, 8'd0);
        @(negedge clk);
        data_in    = 8'ha5;     // second edge lands while encoding
        data_ready = 1'b1;
        @(negedge clk);
        data_ready = 1'b0;
        wait_output_ready();
        check_value("code_out", 32'(code_out), 32'(first));
        run_frame(8'ha5, 1'b1, 1'b0, 8'd0);
        check_value("code_out", 32'(code_out), 32'(second));
    endtask

    initial begin
        clk           = 1'b0;
        rst           = 1'b1;
        data_ready    = 1'b0;
        data_in       = '0;
        bch_enable    = 1'b0;
        inject_enable = 1'b0;
        error_count   = '0;
        lfsr_state    = seed;
        cycles        = 0;
        repeat (3) @(negedge clk);
        rst = 1'b0;
        test_reset_state();
        test_passthrough();
        test_encode_only();
        test_raw_inject();
        test_coded_inject();
        test_ignored_edge();
        test_passthrough();     // code_out still holds the last codeword pair here
        $display("All tests passed!");
        $finish;
    end

endmodule

// ==== verilog/bch_encoder.sv ====
`timescale 1ns/1ps

module bch_encoder (
    input  logic                clk,
    input  logic                rst,
    input  logic                start,
    input  channel_pkg::msg_t   message,
    output channel_pkg::code_t  codeword,
    output logic                done
);

    logic [2:0]                         step_cnt;   // division steps left
    channel_pkg::msg_t                  shift_q;    // message bits, msb first
    channel_pkg::msg_t                  msg_q;      // systematic part
    logic [channel_pkg::parity_w-1:0]   rem_q;
    logic [channel_pkg::parity_w-1:0]   rem_next;
    logic                               fb;

    // one step of the division lfsr
    assign fb       = shift_q[channel_pkg::msg_w-1] ^ rem_q[channel_pkg::parity_w-1];
    assign rem_next = {rem_q[channel_pkg::parity_w-2:0], 1'b0}
                    ^ (fb ? channel_pkg::bch_gen_poly[channel_pkg::parity_w-1:0] : '0);

    // ------------------------------
    // step control
    // ------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            step_cnt <= '0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                step_cnt <= 3'(channel_pkg::msg_w);
            end else if (step_cnt != '0) begin
                step_cnt <= step_cnt - 3'd1;
                if (step_cnt == 3'd1)
                    done <= 1'b1;               // last division step
            end
        end
    end

    // ------------------------------
    // division datapath
    // ------------------------------
    always_ff @(posedge clk) begin
        if (start) begin
            shift_q <= message;
            msg_q   <= message;
            rem_q   <= '0;
        end else if (step_cnt != '0) begin
            shift_q <= {shift_q[channel_pkg::msg_w-2:0], 1'b0};
            rem_q   <= rem_next;
            if (step_cnt == 3'd1)
                codeword <= {msg_q, rem_next};  // held until the next start
        end
    end

    // a done pulse always belongs to a start six cycles back
    a_done_after_start: assert property (
        @(posedge clk) disable iff (rst) done |-> $past(start, 6)
    );

endmodule

// ==== verilog/channel_pkg.sv ====
package channel_pkg;

    // ------------------------------
    // widths
    // ------------------------------
    localparam int data_w   = 8;                 // request word
    localparam int msg_w    = 5;                 // bch message
    localparam int code_w   = 15;                // bch codeword
    localparam int parity_w = code_w - msg_w;    // remainder bits
    localparam int count_w  = 8;

    // x^10 + x^8 + x^5 + x^4 + x^2 + x + 1, corrects up to 3 errors
    localparam logic [parity_w:0] bch_gen_poly = 11'b10100110111;

    // ------------------------------
    // error injector lfsr
    // ------------------------------
    localparam int lfsr_w = 16;
    localparam logic [lfsr_w-1:0] lfsr_taps = 16'hb400;   // maximal length galois taps
    localparam int raw_lfsr_seed  = 16'hace1;
    localparam int code_lfsr_seed = 16'h5a3c;

    // ------------------------------
    // payload types
    // ------------------------------
    typedef logic [data_w-1:0]   data_t;
    typedef logic [msg_w-1:0]    msg_t;
    typedef logic [code_w-1:0]   code_t;
    typedef logic [2*code_w-1:0] code_pair_t;   // high nibble codeword on top
    typedef logic [count_w-1:0]  count_t;

    // frame sequencer
    typedef enum logic [1:0] {
        idle   = 2'd0,
        encode = 2'd1,
        inject = 2'd2,
        done   = 2'd3
    } frame_state_t;

endpackage

// ==== verilog/channel_sequencer.sv ====
`timescale 1ns/1ps

module channel_sequencer (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    data_ready,
    input  channel_pkg::data_t      data_in,
    input  logic                    bch_enable,
    input  logic                    inject_enable,
    input  channel_pkg::count_t     error_count,
    input  logic                    enc_done,
    input  channel_pkg::code_t      code_hi,
    input  channel_pkg::code_t      code_lo,
    input  logic                    raw_inj_done,
    input  channel_pkg::data_t      raw_inj_out,
    input  logic                    code_inj_done,
    input  channel_pkg::code_pair_t code_inj_out,
    output channel_pkg::msg_t       msg_hi,
    output channel_pkg::msg_t       msg_lo,
    output logic                    enc_start,
    output logic                    raw_inj_start,
    output logic                    code_inj_start,
    output channel_pkg::data_t      raw_payload,
    output channel_pkg::code_pair_t code_payload,
    output channel_pkg::count_t     inj_count,
    output channel_pkg::data_t      data_out,
    output channel_pkg::code_pair_t code_out,
    output logic                    output_ready
);

    channel_pkg::frame_state_t state;
    logic                      ready_q;
    logic                      bch_q;
    logic                      inj_q;
    logic                      accept;
    channel_pkg::count_t       count_cap;
    channel_pkg::count_t       count_lim;

    // new request only when no frame is in flight
    assign accept = data_ready && !ready_q
                 && (state == channel_pkg::idle || state == channel_pkg::done);

    assign count_cap = bch_enable ? channel_pkg::count_t'(2 * channel_pkg::code_w)
                                  : channel_pkg::count_t'(channel_pkg::data_w);
    assign count_lim = (error_count > count_cap) ? count_cap : error_count;

    // ------------------------------
    // frame fsm
    // ------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state          <= channel_pkg::idle;
            ready_q        <= 1'b0;
            bch_q          <= 1'b0;
            inj_q          <= 1'b0;
            enc_start      <= 1'b0;
            raw_inj_start  <= 1'b0;
            code_inj_start <= 1'b0;
            output_ready   <= 1'b0;
            data_out       <= '0;
            code_out       <= '0;
        end else begin
            ready_q        <= data_ready;
            enc_start      <= 1'b0;
            raw_inj_start  <= 1'b0;
            code_inj_start <= 1'b0;
            case (state)
                channel_pkg::idle, channel_pkg::done: begin
                    if (accept) begin
                        bch_q        <= bch_enable;
                        inj_q        <= inject_enable;
                        output_ready <= 1'b0;
                        if (bch_enable) begin
                            state     <= channel_pkg::encode;
                            enc_start <= 1'b1;
                        end else if (inject_enable) begin
                            state         <= channel_pkg::inject;
                            raw_inj_start <= 1'b1;
                        end else begin
                            state <= channel_pkg::done;     // plain pass-through
                        end
                    end else if (state == channel_pkg::done && !output_ready) begin
                        data_out     <= raw_payload;
                        code_out     <= '0;
                        output_ready <= 1'b1;
                    end
                end
                channel_pkg::encode: begin
                    if (enc_done) begin     // lo encoder finishes in the same cycle
                        if (inj_q) begin
                            state          <= channel_pkg::inject;
                            code_inj_start <= 1'b1;
                        end else begin
                            state        <= channel_pkg::done;
                            code_out     <= {code_hi, code_lo};
                            data_out     <= '0;
                            output_ready <= 1'b1;
                        end
                    end
                end
                channel_pkg::inject: begin
                    if (bch_q ? code_inj_done : raw_inj_done) begin
                        state        <= channel_pkg::done;
                        output_ready <= 1'b1;
                        if (bch_q) begin
                            code_out <= code_inj_out;
                            data_out <= '0;
                        end else begin
                            data_out <= raw_inj_out;
                            code_out <= '0;
                        end
                    end
                end
                default: state <= channel_pkg::idle;
            endcase
        end
    end

    // ------------------------------
    // request and payload latches
    // ------------------------------
    always_ff @(posedge clk) begin
        if (accept) begin
            msg_hi      <= channel_pkg::msg_t'(data_in[7:4]);   // nibbles, zero extended
            msg_lo      <= channel_pkg::msg_t'(data_in[3:0]);
            raw_payload <= data_in;
            inj_count   <= count_lim;
        end
        if (state == channel_pkg::encode && enc_done)
            code_payload <= {code_hi, code_lo};
    end

    a_ready_idle_only: assert property (
        @(posedge clk) disable iff (rst)
        (state == channel_pkg::encode || state == channel_pkg::inject) |-> !output_ready
    );

endmodule

// ==== verilog/channel_top.sv ====
`timescale 1ns/1ps

module channel_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    data_ready,
    input  channel_pkg::data_t      data_in,
    input  logic                    bch_enable,
    input  logic                    inject_enable,
    input  channel_pkg::count_t     error_count,
    output channel_pkg::data_t      data_out,
    output channel_pkg::code_pair_t code_out,
    output logic                    output_ready
);

    channel_pkg::msg_t       msg_hi;
    channel_pkg::msg_t       msg_lo;
    channel_pkg::code_t      code_hi;
    channel_pkg::code_t      code_lo;
    logic                    enc_start;
    logic                    enc_done;         // from the high encoder only
    logic                    raw_inj_start;
    logic                    raw_inj_done;
    logic                    code_inj_start;
    logic                    code_inj_done;
    channel_pkg::data_t      raw_payload;
    channel_pkg::data_t      raw_inj_out;
    channel_pkg::code_pair_t code_payload;
    channel_pkg::code_pair_t code_inj_out;
    channel_pkg::count_t     inj_count;

    // ------------------------------
    // frame control
    // ------------------------------
    channel_sequencer u_seq (
        .clk            (clk),
        .rst            (rst),
        .data_ready     (data_ready),
        .data_in        (data_in),
        .bch_enable     (bch_enable),
        .inject_enable  (inject_enable),
        .error_count    (error_count),
        .enc_done       (enc_done),
        .code_hi        (code_hi),
        .code_lo        (code_lo),
        .raw_inj_done   (raw_inj_done),
        .raw_inj_out    (raw_inj_out),
        .code_inj_done  (code_inj_done),
        .code_inj_out   (code_inj_out),
        .msg_hi         (msg_hi),
        .msg_lo         (msg_lo),
        .enc_start      (enc_start),
        .raw_inj_start  (raw_inj_start),
        .code_inj_start (code_inj_start),
        .raw_payload    (raw_payload),
        .code_payload   (code_payload),
        .inj_count      (inj_count),
        .data_out       (data_out),
        .code_out       (code_out),
        .output_ready   (output_ready)
    );

    // ------------------------------
    // bch encoders, one per nibble
    // ------------------------------
    bch_encoder enc_hi (.clk(clk), .rst(rst), .start(enc_start), .message(msg_hi),
                        .codeword(code_hi), .done(enc_done));
    bch_encoder enc_lo (.clk(clk), .rst(rst), .start(enc_start), .message(msg_lo),
                        .codeword(code_lo), .done());   // same latency as enc_hi

    // ------------------------------
    // error injectors
    // ------------------------------
    error_injector #(.payload_t(channel_pkg::data_t), .lfsr_seed(channel_pkg::raw_lfsr_seed))
    raw_inj (.clk(clk), .rst(rst), .start(raw_inj_start), .payload_in(raw_payload),
             .error_count(inj_count), .payload_out(raw_inj_out), .done(raw_inj_done));

    error_injector #(.payload_t(channel_pkg::code_pair_t),
                     .lfsr_seed(channel_pkg::code_lfsr_seed))
    code_inj (.clk(clk), .rst(rst), .start(code_inj_start), .payload_in(code_payload),
              .error_count(inj_count), .payload_out(code_inj_out), .done(code_inj_done));

endmodule

// ==== verilog/error_injector.sv ====
`timescale 1ns/1ps

module error_injector #(
    parameter type payload_t = channel_pkg::data_t,
    parameter int  lfsr_seed = 1
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                start,
    input  payload_t            payload_in,
    input  channel_pkg::count_t error_count,
    output payload_t            payload_out,
    output logic                done
);

    localparam int pw    = $bits(payload_t);
    localparam int idx_w = $clog2(pw);

    logic [channel_pkg::lfsr_w-1:0] lfsr_q;
    logic [channel_pkg::lfsr_w-1:0] lfsr_next;
    logic [pw-1:0]                  work_q;     // payload being impaired
    logic [pw-1:0]                  mask_q;     // bits already flipped
    logic [idx_w-1:0]               cand;
    logic                           hit;
    logic                           active_q;
    channel_pkg::count_t            flip_cnt;
    channel_pkg::count_t            flip_next;

    // galois lfsr, shifts right every cycle
    assign lfsr_next = {1'b0, lfsr_q[channel_pkg::lfsr_w-1:1]}
                     ^ (lfsr_q[0] ? channel_pkg::lfsr_taps : '0);

    // candidate bit position for this cycle
    assign cand      = lfsr_q[idx_w-1:0];
    assign hit       = (cand < pw) && !mask_q[cand];
    assign flip_next = flip_cnt + 1'b1;

    assign payload_out = payload_t'(work_q);

    // ------------------------------
    // attempt control
    // ------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lfsr_q   <= channel_pkg::lfsr_w'(lfsr_seed);
            mask_q   <= '0;
            flip_cnt <= '0;
            active_q <= 1'b0;
            done     <= 1'b0;
        end else begin
            lfsr_q <= lfsr_next;
            done   <= 1'b0;
            if (start) begin
                mask_q   <= '0;
                flip_cnt <= '0;
                active_q <= (error_count != '0);
                done     <= (error_count == '0);    // nothing to flip
            end else if (active_q && hit) begin
                mask_q[cand] <= 1'b1;
                flip_cnt     <= flip_next;
                if (flip_next == error_count) begin
                    active_q <= 1'b0;
                    done     <= 1'b1;
                end
            end
        end
    end

    // ------------------------------
    // working copy
    // ------------------------------
    always_ff @(posedge clk) begin
        if (start)
            work_q <= payload_in;
        else if (active_q && hit)
            work_q[cand] <= ~work_q[cand];
    end

    // the sequencer must hold the count steady for the whole run
    a_flip_bound: assert property (
        @(posedge clk) disable iff (rst) active_q |-> (flip_cnt <= error_count)
    );

endmodule
